// File: mem_geom_pkg.sv
package mem_geom_pkg;

    //////////////////////////////////////////////////////////////////////
    // Block geometry
    //////////////////////////////////////////////////////////////////////

    localparam int BLOCK_BYTES = 16;         // Bytes held by one block
    localparam int OFFSET_BITS = 4;          // Byte offset within a block

    // Byte address as seen by the requester
    typedef logic [31:0] mem_addr_t;

    // One block, viewable at every access granularity
    typedef union packed {
        logic [15:0][7:0]  byte_level;
        logic [7:0][15:0]  half_level;
        logic [3:0][31:0]  word_level;
        logic [1:0][63:0]  dbbl_level;
    } mem_block_t;

    //////////////////////////////////////////////////////////////////////
    // Access sizes
    //////////////////////////////////////////////////////////////////////

    // Sub-block sizes are aligned down to their own width
    typedef enum logic [2:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE,
        QUAD                                 // Whole 16-byte block
    } mem_size_e;

endpackage

// File: mem_txn_pkg.sv
package mem_txn_pkg;

    import mem_geom_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Commands and tags
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        MEM_LOAD,
        MEM_STORE                            // Stores return no response
    } mem_cmd_e;

    // Tag zero marks "no tag", usable tags are 1..15
    typedef logic [3:0] mem_tag_t;

    localparam mem_tag_t NO_TAG   = 4'd0;
    localparam int       MAX_TAGS = 15;

    //////////////////////////////////////////////////////////////////////
    // Channel payloads
    //////////////////////////////////////////////////////////////////////

    // Request channel, 164 bits
    typedef struct packed {
        mem_cmd_e   cmd;
        mem_size_e  size;
        mem_addr_t  addr;
        mem_block_t data;                    // Store data, low bytes used
    } mem_req_t;

    // Response channel, 133 bits
    typedef struct packed {
        mem_tag_t   tag;
        logic       err;                     // Address was out of range
        mem_block_t data;                    // Zero-extended load value
    } mem_resp_t;

endpackage

// File: mem_block_array.sv
`timescale 1ns/1ps

module mem_block_array
    import mem_geom_pkg::*, mem_txn_pkg::*;
#(
    parameter int MEM_BLOCKS = 64
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       accept,
    input  mem_req_t   req,
    output mem_block_t load_data,
    output logic       addr_ok
);

    localparam int ADDR_BITS = $bits(mem_addr_t);
    localparam int BLK_FIELD = ADDR_BITS - OFFSET_BITS;
    localparam int IDX_BITS  = (MEM_BLOCKS > 1) ? $clog2(MEM_BLOCKS) : 1;

    mem_block_t blocks [MEM_BLOCKS];

    logic [BLK_FIELD-1:0]   blk_num;
    logic [IDX_BITS-1:0]    blk_idx;
    logic [OFFSET_BITS-1:0] byte_off;
    logic [OFFSET_BITS-2:0] half_idx;
    logic [OFFSET_BITS-3:0] word_idx;
    logic                   dbbl_idx;

    mem_block_t cur_block;
    mem_block_t merged;
    logic       wr_en;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    assign blk_num  = req.addr[ADDR_BITS-1:OFFSET_BITS];
    assign blk_idx  = blk_num[IDX_BITS-1:0];
    assign byte_off = req.addr[OFFSET_BITS-1:0];
    assign half_idx = byte_off[OFFSET_BITS-1:1];     // Aligned down to 2 bytes
    assign word_idx = byte_off[OFFSET_BITS-1:2];
    assign dbbl_idx = byte_off[OFFSET_BITS-1];

    assign addr_ok   = (blk_num < BLK_FIELD'(MEM_BLOCKS));
    assign cur_block = addr_ok ? blocks[blk_idx] : '0;

    //////////////////////////////////////////////////////////////////////
    // Load extraction
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        load_data = '0;                                  // Out of range reads as zero
        if (addr_ok) begin
            case (req.size)
                BYTE:    load_data = {{(BLOCK_BYTES-1){8'h00}}, cur_block.byte_level[byte_off]};
                HALF:    load_data = {{(BLOCK_BYTES-2){8'h00}}, cur_block.half_level[half_idx]};
                WORD:    load_data = {{(BLOCK_BYTES-4){8'h00}}, cur_block.word_level[word_idx]};
                DOUBLE:  load_data = {{(BLOCK_BYTES-8){8'h00}}, cur_block.dbbl_level[dbbl_idx]};
                QUAD:    load_data = cur_block;
                default: load_data = '0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Store merge
    //////////////////////////////////////////////////////////////////////

    // Low bytes of the store data land in the sized field
    always_comb begin
        merged = cur_block;
        case (req.size)
            BYTE:    merged.byte_level[byte_off] = req.data.byte_level[0];
            HALF:    merged.half_level[half_idx] = req.data.half_level[0];
            WORD:    merged.word_level[word_idx] = req.data.word_level[0];
            DOUBLE:  merged.dbbl_level[dbbl_idx] = req.data.dbbl_level[0];
            QUAD:    merged = req.data;
            default: merged = cur_block;                  // Unknown size writes nothing
        endcase
    end

    assign wr_en = accept && addr_ok && (req.cmd == MEM_STORE);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_BLOCKS; i++) begin
                blocks[i] <= '0;
            end
        end else if (wr_en) begin
            blocks[blk_idx] <= merged;
        end
    end

    // Contents only move on an accepted request
    a_hold_without_accept: assert property (
        @(posedge clock) (rst_n && !accept && addr_ok)
            |=> (blocks[$past(blk_idx)] == $past(cur_block))
    );

endmodule

// File: mem_tag_tracker.sv
`timescale 1ns/1ps

module mem_tag_tracker
    import mem_geom_pkg::*, mem_txn_pkg::*;
#(
    parameter int NUM_TAGS = 4,
    parameter int LATENCY  = 6
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       req_valid,
    input  logic       resp_ready,
    input  logic       addr_ok,
    input  mem_cmd_e   req_cmd,
    input  mem_block_t load_data,
    output logic       req_ready,
    output logic       accept,
    output logic       resp_valid,
    output mem_tag_t   req_tag,
    output mem_resp_t  resp
);

    localparam int CNT_BITS = $clog2(LATENCY + 1);

    // Slot state, indexed by tag
    logic [CNT_BITS-1:0] slot_count [1:NUM_TAGS];   // Cycles still to wait
    logic                slot_wait  [1:NUM_TAGS];   // Load waiting for output
    logic                slot_err   [1:NUM_TAGS];
    mem_block_t          slot_data  [1:NUM_TAGS];

    mem_tag_t free_tag;                             // Lowest free slot
    mem_tag_t done_tag;                             // Lowest finished load
    logic     out_take;
    logic     out_load;

    //////////////////////////////////////////////////////////////////////
    // Slot selection
    //////////////////////////////////////////////////////////////////////

    // Walk downwards so the lowest index wins
    always_comb begin
        free_tag = NO_TAG;
        done_tag = NO_TAG;
        for (int i = NUM_TAGS; i >= 1; i--) begin
            if (slot_count[i] == '0 && !slot_wait[i]) begin
                free_tag = mem_tag_t'(i);
            end
            if (slot_count[i] == '0 && slot_wait[i]) begin
                done_tag = mem_tag_t'(i);
            end
        end
    end

    assign req_tag   = free_tag;
    assign req_ready = (free_tag != NO_TAG);
    assign accept    = req_valid && req_ready;

    // Output register can take a new entry when empty or draining
    assign out_take = !resp_valid || resp_ready;
    assign out_load = out_take && (done_tag != NO_TAG);

    //////////////////////////////////////////////////////////////////////
    // Slot control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 1; i <= NUM_TAGS; i++) begin
                slot_count[i] <= '0;
                slot_wait[i]  <= 1'b0;
            end
            resp_valid <= 1'b0;
        end else begin
            for (int i = 1; i <= NUM_TAGS; i++) begin
                if (slot_count[i] != '0) begin
                    slot_count[i] <= slot_count[i] - 1'b1;
                end
                if (out_load && done_tag == mem_tag_t'(i)) begin
                    slot_wait[i] <= 1'b0;              // Slot is free next cycle
                end
                // A free slot is never the finished one, so no conflict here
                if (accept && free_tag == mem_tag_t'(i)) begin
                    slot_count[i] <= CNT_BITS'(LATENCY);
                    slot_wait[i]  <= (req_cmd == MEM_LOAD);
                end
            end
            if (out_take) begin
                resp_valid <= (done_tag != NO_TAG);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Slot payload and output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        for (int i = 1; i <= NUM_TAGS; i++) begin
            if (accept && free_tag == mem_tag_t'(i) && req_cmd == MEM_LOAD) begin
                slot_data[i] <= load_data;             // Captured at acceptance
                slot_err[i]  <= !addr_ok;
            end
        end
        if (out_load) begin
            resp.tag  <= done_tag;
            resp.err  <= slot_err[done_tag];
            resp.data <= slot_data[done_tag];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_resp_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
            (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp))
    );

    a_resp_tag: assert property (
        @(posedge clock) disable iff (!rst_n)
            resp_valid |-> (resp.tag != NO_TAG)
    );

    // Tag zero is reserved, so the pool tops out at 15
    a_num_tags: assert property (
        @(posedge clock) (NUM_TAGS >= 1) && (NUM_TAGS <= MAX_TAGS)
    );

endmodule

// File: tagged_mem.sv
`timescale 1ns/1ps

module tagged_mem
    import mem_geom_pkg::*, mem_txn_pkg::*;
#(
    parameter int NUM_TAGS   = 4,
    parameter int LATENCY    = 6,
    parameter int MEM_BLOCKS = 64
) (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      req_valid,
    input  logic      resp_ready,
    input  mem_req_t  req,
    output logic      req_ready,
    output logic      resp_valid,
    output mem_tag_t  req_tag,
    output mem_resp_t resp
);

    logic       accept;      // Request taken this cycle
    logic       addr_ok;
    mem_block_t load_data;   // Extracted value for the current request

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    mem_block_array #(
        .MEM_BLOCKS (MEM_BLOCKS)
    ) u_array (
        .clock     (clock),
        .rst_n     (rst_n),
        .accept    (accept),
        .req       (req),
        .load_data (load_data),
        .addr_ok   (addr_ok)
    );

    //////////////////////////////////////////////////////////////////////
    // Tags, latency and response channel
    //////////////////////////////////////////////////////////////////////

    mem_tag_tracker #(
        .NUM_TAGS (NUM_TAGS),
        .LATENCY  (LATENCY)
    ) u_tracker (
        .clock      (clock),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .resp_ready (resp_ready),
        .addr_ok    (addr_ok),
        .req_cmd    (req.cmd),
        .load_data  (load_data),
        .req_ready  (req_ready),
        .accept     (accept),
        .resp_valid (resp_valid),
        .req_tag    (req_tag),
        .resp       (resp)
    );

endmodule

// File: tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Shadow memory and random source
//////////////////////////////////////////////////////////////////////

logic [7:0]  shadow [MEM_BYTES];        // One entry per byte of the DUT memory
logic [31:0] lfsr_state = 32'd80;       // Seed

// Galois step, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

// One LFSR step per bit
function automatic logic [127:0] take_bits(input int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v[i]       = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
endfunction

//////////////////////////////////////////////////////////////////////
// Reference load and store
//////////////////////////////////////////////////////////////////////

function automatic logic addr_in_range(input mem_addr_t addr);
    return addr < mem_addr_t'(MEM_BYTES);
endfunction

function automatic int size_bytes(input mem_size_e size);
    return 1 << int'(size);             // 1, 2, 4, 8 or 16
endfunction

function automatic void shadow_clear();
    for (int i = 0; i < MEM_BYTES; i++) begin
        shadow[i] = 8'h00;
    end
endfunction

// Low bytes of the data go to the aligned-down field
function automatic void ref_store(input mem_req_t r);
    int        n;
    mem_addr_t base;
    if (!addr_in_range(r.addr)) begin
        return;                         // Dropped
    end
    n    = size_bytes(r.size);
    base = r.addr & ~mem_addr_t'(n - 1);
    for (int i = 0; i < n; i++) begin
        shadow[int'(base) + i] = r.data.byte_level[i];
    end
endfunction

function automatic mem_resp_t ref_load(input mem_req_t r, input mem_tag_t tag);
    mem_resp_t e;
    int        n;
    mem_addr_t base;
    e.tag  = tag;
    e.err  = !addr_in_range(r.addr);
    e.data = '0;                        // Zero-extended, zero when out of range
    if (!e.err) begin
        n    = size_bytes(r.size);
        base = r.addr & ~mem_addr_t'(n - 1);
        for (int i = 0; i < n; i++) begin
            e.data.byte_level[i] = shadow[int'(base) + i];
        end
    end
    return e;
endfunction

`endif

// File: tagged_mem_tb.sv
`timescale 1ns/1ps

module tagged_mem_tb
    import mem_geom_pkg::*, mem_txn_pkg::*;
();

    localparam int NUM_TAGS   = 4;
    localparam int LATENCY    = 6;
    localparam int MEM_BLOCKS = 64;
    localparam int MEM_BYTES  = MEM_BLOCKS * BLOCK_BYTES;
    localparam int ADDR_W     = $clog2(MEM_BYTES);

    localparam int N_ZERO   = 4;
    localparam int N_RANDOM = 200;
    localparam int N_OOR    = 80;
    localparam int N_TOGGLE = 200;
    localparam int TOTAL_REQS =
        N_ZERO + N_RANDOM + N_OOR + MEM_BLOCKS + NUM_TAGS + 1 + N_TOGGLE + 1;
    localparam int WATCHDOG_NS = TOTAL_REQS * (LATENCY + NUM_TAGS + 20) * 8;

    typedef enum logic [1:0] {READY_HIGH, READY_LOW, READY_RANDOM} ready_mode_e;

    logic      clock = 1'b0;
    logic      rst_n;
    logic      req_valid;
    logic      resp_ready;
    mem_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    mem_tag_t  req_tag;
    mem_resp_t resp;

    ready_mode_e ready_mode;
    logic [31:0] ready_lfsr = 32'd80;   // Own stream for resp_ready
    string       test_name;
    int          checks;
    int          errors;
    mem_resp_t   exp_q [$];             // Expected load responses in acceptance order
    mem_resp_t   held_resp;
    logic        hold_armed;

    `include "tb_ref_model.svh"

    tagged_mem #(
        .NUM_TAGS   (NUM_TAGS),
        .LATENCY    (LATENCY),
        .MEM_BLOCKS (MEM_BLOCKS)
    ) DUT (
        .clock      (clock),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .resp_ready (resp_ready),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .req_tag    (req_tag),
        .resp       (resp)
    );

    always #4 clock = ~clock;           // 8 ns period

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic check(input string what, input logic [132:0] expected,
                         input logic [132:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s, %s: expected %h actual %h", test_name, what,
                     expected, actual);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic match_response(input mem_resp_t r);
        int idx;
        idx = -1;
        for (int i = 0; i < exp_q.size() && idx < 0; i++) begin
            if (exp_q[i].tag == r.tag) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            note_failure($sformatf("response with tag %0d matches no outstanding load", r.tag));
        end else begin
            check("load response", exp_q[idx], r);
            exp_q.delete(idx);
        end
    endtask

    // Sampled mid-cycle so the next rising edge acts on what is seen here
    always @(negedge clock) begin
        if (rst_n) begin
            if (hold_armed) begin
                check("resp_valid under back-pressure", 133'(1), 133'(resp_valid));
                check("held response", held_resp, resp);
            end
            hold_armed = resp_valid && !resp_ready;
            held_resp  = resp;
            if (resp_valid && resp_ready) begin
                match_response(resp);
            end
            if (req_valid && req_ready) begin
                if (req.cmd == MEM_LOAD) begin
                    exp_q.push_back(ref_load(req, req_tag));
                end else begin
                    ref_store(req);
                end
            end
        end
    end

    always @(posedge clock) begin
        case (ready_mode)
            READY_LOW:    resp_ready <= 1'b0;
            READY_RANDOM: begin
                resp_ready <= ready_lfsr[0];
                ready_lfsr <= lfsr_step(ready_lfsr);
            end
            default:      resp_ready <= 1'b1;
        endcase
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns during %s", WATCHDOG_NS, test_name);
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // About one address in eight out of range when allowed
    function automatic mem_req_t make_req(input mem_cmd_e cmd, input logic allow_oor);
        mem_req_t   r;
        logic [2:0] pick;
        r.cmd  = cmd;
        pick   = 3'(take_bits(3));
        r.size = mem_size_e'(pick % 3'd5);
        pick   = 3'(take_bits(3));
        if (allow_oor && pick == 3'd0) begin
            r.addr = mem_addr_t'(MEM_BYTES) + mem_addr_t'(take_bits(16));
        end else begin
            r.addr = mem_addr_t'(take_bits(ADDR_W));
        end
        r.data = take_bits(128);
        return r;
    endfunction

    function automatic mem_cmd_e random_cmd();
        return mem_cmd_e'(1'(take_bits(1)));
    endfunction

    // Called right after a rising edge and returns right after the accepting one
    task automatic send_req(input mem_req_t r);
        req_valid <= 1'b1;
        req       <= r;
        @(negedge clock);
        while (!req_ready) begin
            @(posedge clock);
            @(negedge clock);
        end
        @(posedge clock);
        req_valid <= 1'b0;
    endtask

    // Waits until no load is in flight and store slots have freed
    task automatic wait_idle();
        do begin
            @(posedge clock);
            @(negedge clock);
        end while (exp_q.size() != 0 || resp_valid);
        repeat (LATENCY + 1) @(posedge clock);
    endtask

    task automatic fill_under_backpressure();
        int          taken;
        logic [15:0] tag_seen;
        logic        full;
        test_name  = "back-pressure fill";
        ready_mode <= READY_LOW;
        repeat (2) @(posedge clock);
        taken    = 0;
        tag_seen = '0;
        full     = 1'b0;
        for (int i = 0; i < NUM_TAGS + 2 && !full; i++) begin
            req_valid <= 1'b1;
            req       <= make_req(MEM_LOAD, 1'b0);
            @(negedge clock);
            if (!req_ready) begin
                full = 1'b1;
            end else begin
                if (req_tag == NO_TAG || int'(req_tag) > NUM_TAGS || tag_seen[req_tag]) begin
                    note_failure($sformatf("tag %0d is reused or outside the pool", req_tag));
                end
                tag_seen[req_tag] = 1'b1;
                taken++;
            end
            @(posedge clock);
        end
        check("loads accepted before req_ready fell", 133'(NUM_TAGS), 133'(taken));
        check("req_ready fell", 133'(1), 133'(full));
        ready_mode <= READY_HIGH;               // Pending request gets in once loads drain
        @(negedge clock);
        while (!req_ready) begin
            @(posedge clock);
            @(negedge clock);
        end
        @(posedge clock);
        req_valid <= 1'b0;
        wait_idle();
    endtask

    task automatic measure_latency();
        int   edges;
        logic seen;
        test_name = "load latency";
        wait_idle();
        send_req(make_req(MEM_LOAD, 1'b0));
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < 4 * (LATENCY + 1)) begin
            @(posedge clock);
            edges++;
            @(negedge clock);
            seen = resp_valid;
        end
        check("edges from acceptance to resp_valid", 133'(LATENCY + 1), 133'(edges));
        wait_idle();
    endtask

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        resp_ready = 1'b0;
        req        = '0;
        ready_mode = READY_HIGH;
        test_name  = "reset";
        checks     = 0;
        errors     = 0;
        hold_armed = 1'b0;
        shadow_clear();
        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check("req_ready after reset", 133'(1), 133'(req_ready));
        check("resp_valid after reset", 133'(0), 133'(resp_valid));
        @(posedge clock);

        test_name = "loads after reset";
        for (int i = 0; i < N_ZERO; i++) begin
            send_req(make_req(MEM_LOAD, 1'b0));
        end
        wait_idle();

        test_name = "random traffic";
        for (int i = 0; i < N_RANDOM; i++) begin
            send_req(make_req(random_cmd(), 1'b0));
        end
        wait_idle();

        test_name = "out of range";
        for (int i = 0; i < N_OOR; i++) begin
            send_req(make_req(random_cmd(), 1'b1));
        end
        wait_idle();
        test_name = "block sweep";              // Whole memory read back
        for (int i = 0; i < MEM_BLOCKS; i++) begin
            send_req('{cmd: MEM_LOAD, size: QUAD, addr: mem_addr_t'(i * BLOCK_BYTES), data: '0});
        end
        wait_idle();

        fill_under_backpressure();

        test_name  = "random back-pressure";
        ready_mode <= READY_RANDOM;
        for (int i = 0; i < N_TOGGLE; i++) begin
            send_req(make_req(random_cmd(), 1'b1));
        end
        ready_mode <= READY_HIGH;
        wait_idle();

        measure_latency();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
mem_geom_pkg.sv
mem_txn_pkg.sv
mem_block_array.sv
mem_tag_tracker.sv
tagged_mem.sv
tagged_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

LOG=sim.log
BIN=tagged_mem_sim

command -v verilator > /dev/null 2>&1
if [ $? -ne 0 ]; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --assert -Wno-fatal --top-module tagged_mem_tb -f sources.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -qx "No errors" "$LOG"
if [ $? -eq 0 ]; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
